//--- hw/rob_cfg.svh
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// Any power of two works as the buffer depth
`define ROB_DEPTH 8

`define DISP_WIDTH 2
`define RET_WIDTH 2
`define WB_PORTS 2

`endif

//--- hw/isa_pkg.sv
package isa_pkg;

  // Architectural register number
  typedef logic [4:0] reg_idx_t;

  // Data word
  typedef logic [31:0] word_t;

endpackage

//--- hw/rob_pkg.sv
`include "rob_cfg.svh"

package rob_pkg;
  import isa_pkg::*;

  typedef logic [$clog2(`ROB_DEPTH)-1:0] slot_t;

  // One bit wider so a full buffer fits
  typedef logic [$clog2(`ROB_DEPTH):0] count_t;

  typedef struct packed {
    reg_idx_t dest;
    logic     dest_valid;
    word_t    result;
    logic     done;
    logic     killed;
  } rob_entry_t;

  // value is meaningful when ready, tag when not
  typedef struct packed {
    logic  ready;
    word_t value;
    slot_t tag;
  } operand_t;

endpackage

//--- hw/rob_if.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

// Group allocation at the tail
interface alloc_if import isa_pkg::*, rob_pkg::*; ();
  logic                           valid;
  logic [$clog2(`DISP_WIDTH)-1:0] count;
  reg_idx_t                       dest [`DISP_WIDTH];
  logic                           dest_valid [`DISP_WIDTH];
  slot_t                          slot [`DISP_WIDTH];
  logic                           not_full;
  // Bit i set when slot tail+i is free
  logic [`DISP_WIDTH-1:0]         tail_mask;

  modport disp (
    output valid, count, dest, dest_valid,
    input  slot, not_full, tail_mask
  );

  modport rob (
    input  valid, count, dest, dest_valid,
    output slot, not_full, tail_mask
  );
endinterface

// Operand producer search, answered in the same cycle
interface lookup_if import isa_pkg::*, rob_pkg::*; ();
  slot_t    bound [`DISP_WIDTH];
  reg_idx_t src [`DISP_WIDTH][2];
  logic     present [`DISP_WIDTH][2];
  operand_t op [`DISP_WIDTH][2];

  modport disp (
    output bound, src,
    input  present, op
  );

  modport rob (
    input  bound, src,
    output present, op
  );
endinterface

// Head window and release
interface retire_if import rob_pkg::*; ();
  rob_entry_t                    head [`RET_WIDTH];
  logic                          occupied [`RET_WIDTH];
  logic                          rel_valid;
  // Released entries minus one
  logic [$clog2(`RET_WIDTH)-1:0] rel_count;

  modport rob (
    output head, occupied,
    input  rel_valid, rel_count
  );

  modport ret (
    input  head, occupied,
    output rel_valid, rel_count
  );
endinterface

//--- hw/dispatch_stage.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module dispatch_stage import isa_pkg::*, rob_pkg::*; (
  input  logic                           clock,
  input  logic                           reset_n,
  alloc_if.disp                          alloc,
  lookup_if.disp                         look,
  output reg_idx_t                       rf_addr_o [`DISP_WIDTH][2],
  input  word_t                          rf_data_i [`DISP_WIDTH][2],
  input  logic                           disp_valid_i,
  input  logic [$clog2(`DISP_WIDTH)-1:0] disp_count_i,
  input  reg_idx_t                       disp_dest_i [`DISP_WIDTH],
  input  logic                           disp_dest_valid_i [`DISP_WIDTH],
  input  reg_idx_t                       disp_src_a_i [`DISP_WIDTH],
  input  reg_idx_t                       disp_src_b_i [`DISP_WIDTH],
  output logic                           disp_ready_o,
  output slot_t                          disp_slot_o [`DISP_WIDTH],
  output operand_t                       src_a_o [`DISP_WIDTH],
  output operand_t                       src_b_o [`DISP_WIDTH]
);

  logic started_q;

  // Hold off dispatch until the first edge out of reset
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      started_q <= 1'b0;
    end else begin
      started_q <= 1'b1;
    end
  end

  assign disp_ready_o = alloc.not_full & started_q;
  // Group must fit from the tail onward
  assign alloc.valid  = disp_valid_i & started_q & alloc.tail_mask[disp_count_i];
  assign alloc.count  = disp_count_i;

  always_comb begin
    for (int l = 0; l < `DISP_WIDTH; l++) begin
      alloc.dest[l]       = disp_dest_i[l];
      alloc.dest_valid[l] = disp_dest_valid_i[l];
      disp_slot_o[l]      = alloc.slot[l];
      look.bound[l]       = alloc.slot[l];
      look.src[l][0]      = disp_src_a_i[l];
      look.src[l][1]      = disp_src_b_i[l];
      rf_addr_o[l][0]     = disp_src_a_i[l];
      rf_addr_o[l][1]     = disp_src_b_i[l];
    end
  end

  always_comb begin
    reg_idx_t src;
    operand_t res;
    for (int l = 0; l < `DISP_WIDTH; l++) begin
      for (int s = 0; s < 2; s++) begin
        src = look.src[l][s];
        if (look.present[l][s]) begin
          res = look.op[l][s];
        end else begin
          res = '{ready: 1'b1, value: rf_data_i[l][s], tag: '0};
        end
        // Youngest producer among the earlier lanes of the group wins
        for (int j = 0; j < l; j++) begin
          if (disp_dest_valid_i[j] && disp_dest_i[j] == src) begin
            res = '{ready: 1'b0, value: '0, tag: alloc.slot[j]};
          end
        end
        if (s == 0) begin
          src_a_o[l] = res;
        end else begin
          src_b_o[l] = res;
        end
      end
    end
  end

endmodule

//--- hw/rob.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob import isa_pkg::*, rob_pkg::*; (
  input  logic   clock,
  input  logic   reset_n,
  alloc_if.rob   alloc,
  lookup_if.rob  look,
  retire_if.rob  ret,
  input  logic   wb_valid_i [`WB_PORTS],
  input  slot_t  wb_slot_i [`WB_PORTS],
  input  word_t  wb_result_i [`WB_PORTS],
  input  logic   flush_i,
  input  slot_t  flush_slot_i,
  output count_t used_count_o
);

  rob_entry_t entries [`ROB_DEPTH];
  slot_t      head_q;
  slot_t      tail_q;
  count_t     used_q;
  logic       take;
  count_t     add_n;
  count_t     rel_n;

  assign take  = alloc.valid & alloc.not_full;
  assign add_n = take ? count_t'(alloc.count) + count_t'(1) : '0;
  assign rel_n = ret.rel_valid ? count_t'(ret.rel_count) + count_t'(1) : '0;

  // Room for a whole group
  assign alloc.not_full = used_q <= count_t'(`ROB_DEPTH - `DISP_WIDTH);

  always_comb begin
    for (int i = 0; i < `DISP_WIDTH; i++) begin
      alloc.slot[i]      = tail_q + slot_t'(i);
      alloc.tail_mask[i] = (used_q + count_t'(i)) < count_t'(`ROB_DEPTH);
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      head_q <= '0;
      tail_q <= '0;
      used_q <= '0;
    end else begin
      tail_q <= tail_q + slot_t'(add_n);
      head_q <= head_q + slot_t'(rel_n);
      used_q <= used_q + add_n - rel_n;
    end
  end

  always_ff @(posedge clock) begin
    slot_t off;
    if (take) begin
      for (int i = 0; i < `DISP_WIDTH; i++) begin
        if (i <= int'(alloc.count)) begin
          entries[alloc.slot[i]].dest       <= alloc.dest[i];
          entries[alloc.slot[i]].dest_valid <= alloc.dest_valid[i];
          entries[alloc.slot[i]].done       <= 1'b0;
          entries[alloc.slot[i]].killed     <= 1'b0;
        end
      end
    end
    for (int p = 0; p < `WB_PORTS; p++) begin
      if (wb_valid_i[p]) begin
        entries[wb_slot_i[p]].result <= wb_result_i[p];
        entries[wb_slot_i[p]].done   <= 1'b1;
      end
    end
    // Kill everything between the flush slot and the tail
    if (flush_i) begin
      for (int j = 0; j < `ROB_DEPTH; j++) begin
        off = slot_t'(j) - head_q;
        if (count_t'(off) < used_q && off > slot_t'(flush_slot_i - head_q)) begin
          entries[j].killed <= 1'b1;
          entries[j].done   <= 1'b1;
        end
      end
    end
  end

  // Walk back from the boundary towards the head so the first hit is the youngest
  always_comb begin
    slot_t k;
    slot_t span;
    logic  hit;
    for (int l = 0; l < `DISP_WIDTH; l++) begin
      for (int s = 0; s < 2; s++) begin
        look.present[l][s] = 1'b0;
        look.op[l][s]      = '0;
        hit                = 1'b0;
        span               = look.bound[l] - head_q;
        for (int d = 1; d <= `ROB_DEPTH; d++) begin
          k = look.bound[l] - slot_t'(d);
          if (!hit && d <= int'(span) && (int'(span) - d) < int'(used_q) &&
              entries[k].dest_valid && !entries[k].killed &&
              entries[k].dest == look.src[l][s]) begin
            hit                = 1'b1;
            look.present[l][s] = 1'b1;
            look.op[l][s]      = '{ready: entries[k].done, value: entries[k].result, tag: k};
          end
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `RET_WIDTH; i++) begin
      ret.head[i]     = entries[head_q + slot_t'(i)];
      ret.occupied[i] = count_t'(i) < used_q;
    end
  end

  assign used_count_o = used_q;

endmodule

//--- hw/retire_stage.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module retire_stage import isa_pkg::*; (
  input  logic     clock,
  input  logic     reset_n,
  retire_if.ret    ret,
  input  logic     retire_ready_i,
  input  reg_idx_t rf_addr_i [`DISP_WIDTH][2],
  output word_t    rf_data_o [`DISP_WIDTH][2],
  output logic     retire_valid_o [`RET_WIDTH],
  output reg_idx_t retire_reg_o [`RET_WIDTH],
  output word_t    retire_value_o [`RET_WIDTH]
);

  localparam int CW = $clog2(`RET_WIDTH);

  word_t       rf_q [2**$bits(reg_idx_t)];
  logic        wr_en [`RET_WIDTH];
  logic [CW:0] n_take;

  always_comb begin
    logic chain;
    chain  = 1'b1;
    n_take = '0;
    for (int i = 0; i < `RET_WIDTH; i++) begin
      // In-order prefix of done entries
      chain             = chain & ret.occupied[i] & ret.head[i].done;
      n_take            = n_take + (CW+1)'(chain);
      retire_valid_o[i] = chain & ~ret.head[i].killed;
      retire_reg_o[i]   = ret.head[i].dest;
      retire_value_o[i] = ret.head[i].result;
      wr_en[i]          = retire_valid_o[i] & ret.head[i].dest_valid &
                          (ret.head[i].dest != '0);
    end
  end

  assign ret.rel_valid = retire_ready_i & (n_take != '0);
  assign ret.rel_count = CW'(n_take - 1'b1);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int r = 0; r < 2**$bits(reg_idx_t); r++) begin
        rf_q[r] <= '0;
      end
    end else if (retire_ready_i) begin
      // Later lane is younger and lands last
      for (int i = 0; i < `RET_WIDTH; i++) begin
        if (wr_en[i]) begin
          rf_q[ret.head[i].dest] <= ret.head[i].result;
        end
      end
    end
  end

  always_comb begin
    for (int l = 0; l < `DISP_WIDTH; l++) begin
      for (int s = 0; s < 2; s++) begin
        rf_data_o[l][s] = rf_q[rf_addr_i[l][s]];
      end
    end
  end

endmodule

//--- hw/rob_core_top.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_core_top import isa_pkg::*, rob_pkg::*; (
  input  logic                           clock,
  input  logic                           reset_n,
  input  logic                           disp_valid_i,
  input  logic [$clog2(`DISP_WIDTH)-1:0] disp_count_i,
  input  reg_idx_t                       disp_dest_i [`DISP_WIDTH],
  input  logic                           disp_dest_valid_i [`DISP_WIDTH],
  input  reg_idx_t                       disp_src_a_i [`DISP_WIDTH],
  input  reg_idx_t                       disp_src_b_i [`DISP_WIDTH],
  output logic                           disp_ready_o,
  output slot_t                          disp_slot_o [`DISP_WIDTH],
  output operand_t                       src_a_o [`DISP_WIDTH],
  output operand_t                       src_b_o [`DISP_WIDTH],
  input  logic                           wb_valid_i [`WB_PORTS],
  input  slot_t                          wb_slot_i [`WB_PORTS],
  input  word_t                          wb_result_i [`WB_PORTS],
  input  logic                           flush_i,
  input  slot_t                          flush_slot_i,
  input  logic                           retire_ready_i,
  output logic                           retire_valid_o [`RET_WIDTH],
  output reg_idx_t                       retire_reg_o [`RET_WIDTH],
  output word_t                          retire_value_o [`RET_WIDTH],
  output count_t                         used_count_o
);

  alloc_if  alloc_bus ();
  lookup_if look_bus ();
  retire_if ret_bus ();

  // Committed register reads for operand resolution
  reg_idx_t rf_addr [`DISP_WIDTH][2];
  word_t    rf_data [`DISP_WIDTH][2];

  dispatch_stage dispatch_stage_i (
    .clock             (clock),
    .reset_n           (reset_n),
    .alloc             (alloc_bus.disp),
    .look              (look_bus.disp),
    .rf_addr_o         (rf_addr),
    .rf_data_i         (rf_data),
    .disp_valid_i      (disp_valid_i),
    .disp_count_i      (disp_count_i),
    .disp_dest_i       (disp_dest_i),
    .disp_dest_valid_i (disp_dest_valid_i),
    .disp_src_a_i      (disp_src_a_i),
    .disp_src_b_i      (disp_src_b_i),
    .disp_ready_o      (disp_ready_o),
    .disp_slot_o       (disp_slot_o),
    .src_a_o           (src_a_o),
    .src_b_o           (src_b_o)
  );

  rob rob_i (
    .clock        (clock),
    .reset_n      (reset_n),
    .alloc        (alloc_bus.rob),
    .look         (look_bus.rob),
    .ret          (ret_bus.rob),
    .wb_valid_i   (wb_valid_i),
    .wb_slot_i    (wb_slot_i),
    .wb_result_i  (wb_result_i),
    .flush_i      (flush_i),
    .flush_slot_i (flush_slot_i),
    .used_count_o (used_count_o)
  );

  retire_stage retire_stage_i (
    .clock          (clock),
    .reset_n        (reset_n),
    .ret            (ret_bus.ret),
    .retire_ready_i (retire_ready_i),
    .rf_addr_i      (rf_addr),
    .rf_data_o      (rf_data),
    .retire_valid_o (retire_valid_o),
    .retire_reg_o   (retire_reg_o),
    .retire_value_o (retire_value_o)
  );

endmodule

//--- tb/tb_rob_core.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module tb_rob_core import isa_pkg::*, rob_pkg::*; ();
  localparam int D = `ROB_DEPTH;

  logic clock, reset_n, disp_valid_i, disp_ready_o, flush_i, retire_ready_i;
  logic [$clog2(`DISP_WIDTH)-1:0] disp_count_i;
  reg_idx_t disp_dest_i [`DISP_WIDTH], disp_src_a_i [`DISP_WIDTH], disp_src_b_i [`DISP_WIDTH];
  logic     disp_dest_valid_i [`DISP_WIDTH];
  slot_t    disp_slot_o [`DISP_WIDTH];
  operand_t src_a_o [`DISP_WIDTH], src_b_o [`DISP_WIDTH];
  logic     wb_valid_i [`WB_PORTS];
  slot_t    wb_slot_i [`WB_PORTS];
  word_t    wb_result_i [`WB_PORTS];
  slot_t    flush_slot_i;
  logic     retire_valid_o [`RET_WIDTH];
  reg_idx_t retire_reg_o [`RET_WIDTH];
  word_t    retire_value_o [`RET_WIDTH];
  count_t   used_count_o;

  // Reference model with the occupied slots queued from head to tail
  rob_entry_t  m_ent [D];
  int          m_q [$];
  int          m_head;
  word_t       m_rf [32];
  logic [15:0] lfsr_q = 16'd3310;

  rob_core_top rob_core_top_i (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic fail_now(string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else
      fail_now($sformatf("** Error %s: expected %0h, actual %0h", name, exp, act));
  endtask

  task automatic check_op(string name, operand_t exp, operand_t act);
    check_val({name, " ready"}, exp.ready, act.ready);
    if (exp.ready) begin
      check_val({name, " value"}, exp.value, act.value);
    end else begin
      check_val({name, " tag"}, exp.tag, act.tag);
    end
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b      = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], b};
      r      = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic operand_t expect_op(int lane, reg_idx_t r);
    operand_t   o;
    rob_entry_t e;
    o = '{ready: 1'b1, value: m_rf[r], tag: '0};
    foreach (m_q[i]) begin
      e = m_ent[m_q[i]];
      if (e.dest_valid && !e.killed && e.dest == r) begin
        o = '{ready: e.done, value: e.result, tag: slot_t'(m_q[i])};
      end
    end
    if (lane == 1 && disp_dest_valid_i[0] && disp_dest_i[0] == r) begin
      o = '{ready: 1'b0, value: '0, tag: slot_t'(m_head + m_q.size())};
    end
    return o;
  endfunction

  // Check one cycle, then advance the model across the rising edge
  task automatic tick();
    rob_entry_t rel [$];
    logic       chain;
    logic       take;
    int         tail;
    #1;
    tail = (m_head + m_q.size()) % D;
    take = disp_valid_i && m_q.size() <= D - `DISP_WIDTH;
    check_val("used_count", m_q.size(), used_count_o);
    check_val("disp_ready", m_q.size() <= D - `DISP_WIDTH, disp_ready_o);
    for (int l = 0; take && l <= int'(disp_count_i); l++) begin
      check_val("disp_slot", (tail + l) % D, disp_slot_o[l]);
      check_op("src_a", expect_op(l, disp_src_a_i[l]), src_a_o[l]);
      check_op("src_b", expect_op(l, disp_src_b_i[l]), src_b_o[l]);
    end
    chain = 1'b1;
    for (int i = 0; i < `RET_WIDTH; i++) begin
      chain = chain && i < m_q.size() && m_ent[m_q[i]].done;
      check_val("retire_valid", chain && !m_ent[m_q[i]].killed, retire_valid_o[i]);
      if (retire_valid_o[i]) begin
        check_val("retire_reg", m_ent[m_q[i]].dest, retire_reg_o[i]);
        check_val("retire_value", m_ent[m_q[i]].result, retire_value_o[i]);
      end
      if (chain && retire_ready_i) begin
        rel.push_back(m_ent[m_q[i]]);
      end
    end
    @(posedge clock);
    for (int i = 0; flush_i && i < m_q.size(); i++) begin
      if (i > (int'(flush_slot_i) - m_head + D) % D) begin
        m_ent[m_q[i]].killed = 1'b1;
        m_ent[m_q[i]].done   = 1'b1;
      end
    end
    for (int p = 0; p < `WB_PORTS; p++) begin
      if (wb_valid_i[p]) begin
        m_ent[wb_slot_i[p]].result = wb_result_i[p];
        m_ent[wb_slot_i[p]].done   = 1'b1;
      end
    end
    for (int l = 0; take && l <= int'(disp_count_i); l++) begin
      m_ent[(tail + l) % D] = '{dest: disp_dest_i[l], dest_valid: disp_dest_valid_i[l],
                                result: '0, done: 1'b0, killed: 1'b0};
      m_q.push_back((tail + l) % D);
    end
    foreach (rel[i]) begin
      void'(m_q.pop_front());
      if (!rel[i].killed && rel[i].dest_valid && rel[i].dest != '0) begin
        m_rf[rel[i].dest] = rel[i].result;
      end
    end
    m_head = (m_head + rel.size()) % D;
    @(negedge clock);
  endtask

  // Lane 1 always reads lane 0's destination
  task automatic send_group(reg_idx_t d0, reg_idx_t d1, reg_idx_t s0, reg_idx_t s1);
    disp_valid_i = 1'b1;
    disp_count_i = 1'b1;
    disp_dest_i  = '{d0, d1};
    disp_src_a_i = '{s0, d0};
    disp_src_b_i = '{s1, s1};
    tick();
    disp_valid_i = 1'b0;
  endtask

  task automatic rand_group();
    send_group(reg_idx_t'(rand_bits(5)), reg_idx_t'(rand_bits(5)),
               reg_idx_t'(rand_bits(5)), reg_idx_t'(rand_bits(5)));
  endtask

  task automatic write_back(int port, int slot, word_t val);
    wb_valid_i[port]  = 1'b1;
    wb_slot_i[port]   = slot_t'(slot);
    wb_result_i[port] = val;
    tick();
    wb_valid_i[port] = 1'b0;
  endtask

  // Pending entries in random order on random ports
  task automatic wb_random();
    int pend [$];
    int k;
    foreach (m_q[i]) begin
      if (!m_ent[m_q[i]].done) pend.push_back(m_q[i]);
    end
    while (pend.size() > 0) begin
      k = rand_bits(3) % pend.size();
      write_back(rand_bits(1), pend[k], rand_bits(32));
      pend.delete(k);
    end
  endtask

  task automatic drain();
    int t;
    t = 0;
    retire_ready_i = 1'b1;
    while (used_count_o != 0) begin
      if (t++ > 40) fail_now("Timeout: reorder buffer did not drain");
      tick();
    end
  endtask

  initial begin
    int t;
    reset_n           = 1'b0;
    disp_valid_i      = 1'b0;
    disp_count_i      = '0;
    disp_dest_i       = '{default: '0};
    disp_dest_valid_i = '{default: 1'b1};
    disp_src_a_i      = '{default: '0};
    disp_src_b_i      = '{default: '0};
    wb_valid_i        = '{default: 1'b0};
    wb_slot_i         = '{default: '0};
    wb_result_i       = '{default: '0};
    flush_i           = 1'b0;
    flush_slot_i      = '0;
    retire_ready_i    = 1'b1;
    m_head            = 0;
    m_rf              = '{default: '0};
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
    t = 0;
    while (!disp_ready_o) begin
      if (t++ > 5) fail_now("Timeout: dispatch never became ready after reset");
      @(negedge clock);
    end
    check_val("reset used_count", 0, used_count_o);
    check_val("reset retire_valid 0", 0, retire_valid_o[0]);
    check_val("reset retire_valid 1", 0, retire_valid_o[1]);

    // In-flight producers, early result of a younger entry, then commit
    send_group(5'd3, 5'd4, 5'd9, 5'd10);
    send_group(5'd9, 5'd10, 5'd3, 5'd4);
    write_back(1, m_q[3], rand_bits(32));
    send_group(5'd12, 5'd13, 5'd10, 5'd3);
    wb_random();
    drain();
    send_group(5'd14, 5'd15, 5'd9, 5'd12);
    rand_group();
    wb_random();
    drain();

    // Fill without write-back, then a refused group
    t = 0;
    while (disp_ready_o) begin
      if (t++ > D) fail_now("Timeout: buffer never reported full");
      rand_group();
    end
    rand_group();
    wb_random();
    drain();

    // Flush at the second entry of four
    rand_group();
    rand_group();
    flush_i      = 1'b1;
    flush_slot_i = slot_t'(m_q[1]);
    tick();
    flush_i = 1'b0;
    rand_group();
    wb_random();
    drain();

    // Back-pressure with completed entries at the head
    rand_group();
    retire_ready_i = 1'b0;
    write_back(0, m_q[0], rand_bits(32));
    write_back(1, m_q[1], rand_bits(32));
    repeat (2 + rand_bits(2)) tick();
    drain();

    $display("ALL TESTS PASSED");
    $finish;
  end

  assert property (@(posedge clock) disable iff (!reset_n)
      (!retire_ready_i && !(disp_valid_i && disp_ready_o)) |=> $stable(used_count_o))
    else fail_now("used_count_o changed while retirement was held and no group was taken");

  assert property (@(posedge clock) disable iff (!reset_n)
      (!retire_ready_i && !wb_valid_i[0] && !wb_valid_i[1] && !flush_i) |=>
      ($stable(retire_valid_o[0]) && $stable(retire_reg_o[0]) && $stable(retire_value_o[0]) &&
       $stable(retire_valid_o[1]) && $stable(retire_reg_o[1]) && $stable(retire_value_o[1])))
    else fail_now("retire outputs changed while retirement was held");

endmodule

//--- flist.f
+incdir+hw
hw/isa_pkg.sv
hw/rob_pkg.sv
hw/rob_if.sv
hw/dispatch_stage.sv
hw/rob.sv
hw/retire_stage.sv
hw/rob_core_top.sv
tb/tb_rob_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rob_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module rob_core_top -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
